// ==== src/avmm_xlate_config.svh ====
/*
 * avmm translator configuration
 * widths, slot count and fixed slave timing for the fabric endpoint
 */

`ifndef AVMM_XLATE_CONFIG_SVH
`define AVMM_XLATE_CONFIG_SVH

// --------------------------------------------------
// widths and slot count
// --------------------------------------------------
`define AVX_NUM_SLOTS         4   // slave ports behind the endpoint
`define AVX_SLOT_BITS         2
`define AVX_WORD_ADDR_W       12  // slave word address
`define AVX_LANE_BITS         2   // byte lane inside a word
`define AVX_DATA_W            32
`define AVX_BE_W              4

// --------------------------------------------------
// slave timing, in clock cycles
// --------------------------------------------------
`define AVX_SETUP_CYCLES      1
`define AVX_READ_WAIT_CYCLES  2
`define AVX_WRITE_WAIT_CYCLES 1
`define AVX_HOLD_CYCLES       1
`define AVX_READ_LATENCY      2   // at least 1
`define AVX_CNT_W             3   // covers max(S+R, S+W+H)

`endif

// ==== src/avmm_xlate_pkg.sv ====
/*
 * avmm translator types
 * upstream address union plus data, byte enable and slot types
 */

`default_nettype none

`include "avmm_xlate_config.svh"

package avmm_xlate_pkg;

   localparam int UAV_ADDR_W = `AVX_SLOT_BITS + `AVX_WORD_ADDR_W + `AVX_LANE_BITS;

   typedef logic [`AVX_DATA_W-1:0]      data_t;
   typedef logic [`AVX_BE_W-1:0]        be_t;
   typedef logic [`AVX_WORD_ADDR_W-1:0] word_addr_t;
   typedef logic [`AVX_SLOT_BITS-1:0]   slot_id_t;

   // --------------------------------------------------
   // upstream byte address, two views of one word
   // --------------------------------------------------
   typedef struct packed {
      slot_id_t                  slot;  // selects the slave port
      word_addr_t                word;
      logic [`AVX_LANE_BITS-1:0] lane;  // ignored, accesses are aligned
   } uav_fields_t;

   typedef union packed {
      logic [UAV_ADDR_W-1:0] flat;
      uav_fields_t           f;
   } uav_addr_t;

endpackage

`default_nettype wire

// ==== src/avmm_xlate_if.sv ====
/*
 * per-slot link between decoder, translator and return mux
 */

`timescale 1ns/1ps
`default_nettype none

interface xlate_slot_if;

   // command side, driven by the decoder
   logic                       read;
   logic                       write;
   avmm_xlate_pkg::word_addr_t word_addr;
   avmm_xlate_pkg::data_t      writedata;
   avmm_xlate_pkg::be_t        byteenable;

   // translator results
   logic                       waitrequest;
   logic                       rvalid;    // read data present this cycle

   avmm_xlate_pkg::data_t      rdata;     // straight from the slave port

   modport cmd (
      output read, write, word_addr, writedata, byteenable,
      input  waitrequest
   );

   modport xlate (
      input  read, write, word_addr, writedata, byteenable,
      output waitrequest, rvalid
   );

   modport ret (
      input rvalid, rdata
   );

endinterface

`default_nettype wire

// ==== src/slot_decoder.sv ====
/*
 * slot decoder
 * splits the upstream byte address into slot and word, steers the
 * command to one slot and returns that slot's waitrequest
 */

`timescale 1ns/1ps
`default_nettype none

`include "avmm_xlate_config.svh"

module slot_decoder (
   input  avmm_xlate_pkg::uav_addr_t uav_address,
   input  logic                      uav_read,
   input  logic                      uav_write,
   input  avmm_xlate_pkg::data_t     uav_writedata,
   input  avmm_xlate_pkg::be_t       uav_byteenable,
   output logic                      uav_waitrequest,
   xlate_slot_if.cmd                 slots [`AVX_NUM_SLOTS]
);

   avmm_xlate_pkg::slot_id_t  sel;
   logic [`AVX_NUM_SLOTS-1:0] slot_wait;

   assign sel = uav_address.f.slot;

   // --------------------------------------------------
   // per-slot command steering
   // --------------------------------------------------
   generate
      for (genvar g = 0; g < `AVX_NUM_SLOTS; g++) begin : g_slot
         logic hit;

         assign hit = (sel == avmm_xlate_pkg::slot_id_t'(g));

         assign slots[g].read       = uav_read & hit;
         assign slots[g].write      = uav_write & hit;
         assign slots[g].word_addr  = uav_address.f.word;  // lane bits dropped
         assign slots[g].writedata  = uav_writedata;
         assign slots[g].byteenable = uav_byteenable;

         assign slot_wait[g] = slots[g].waitrequest;
      end
   endgenerate

   // addressed slot owns the upstream handshake
   assign uav_waitrequest = slot_wait[sel];

endmodule

`default_nettype wire

// ==== src/wait_state_xlate.sv ====
/*
 * wait-state translator for one fixed-timing slave
 * builds setup, wait and hold windows plus waitrequest from a cycle
 * counter, and turns the fixed read latency into rvalid
 */

`timescale 1ns/1ps
`default_nettype none

`include "avmm_xlate_config.svh"

module wait_state_xlate (
   input  logic                       clk,
   input  logic                       reset,
   xlate_slot_if.xlate                slot,
   output avmm_xlate_pkg::word_addr_t av_address,
   output avmm_xlate_pkg::data_t      av_writedata,
   output avmm_xlate_pkg::be_t        av_byteenable,
   output avmm_xlate_pkg::be_t        av_writebyteenable,
   output logic                       av_read,
   output logic                       av_write,
   output logic                       av_chipselect,
   output logic                       av_begintransfer
);

   localparam int SETUP      = `AVX_SETUP_CYCLES;
   localparam int READ_DONE  = `AVX_SETUP_CYCLES + `AVX_READ_WAIT_CYCLES;
   localparam int WRITE_END  = `AVX_SETUP_CYCLES + `AVX_WRITE_WAIT_CYCLES;
   localparam int WRITE_DONE = WRITE_END + `AVX_HOLD_CYCLES;
   localparam int LAT        = `AVX_READ_LATENCY;

   logic [`AVX_CNT_W-1:0] wait_cnt;     // cycles since the command showed up
   logic                  rst_override; // holds waitrequest after reset
   logic                  end_bt;       // begintransfer already issued
   logic [LAT-1:0]        lat_sr;       // one bit per read in flight
   logic                  cmd;
   logic                  rd_accept;

   assign cmd       = slot.read | slot.write;
   assign rd_accept = slot.read & ~slot.waitrequest;

   // --------------------------------------------------
   // passthrough
   // --------------------------------------------------
   assign av_address         = slot.word_addr;
   assign av_writedata       = slot.writedata;
   assign av_byteenable      = slot.byteenable;
   assign av_writebyteenable = slot.byteenable & {`AVX_BE_W{slot.write}};

   // --------------------------------------------------
   // wait counter and reset override
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt     <= '0;
         rst_override <= 1'b1;
      end else begin
         rst_override <= 1'b0;
         if (!slot.waitrequest || rst_override || !cmd) begin
            wait_cnt <= '0;   // idle or just accepted
         end else begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

   // strobe windows and waitrequest from the count
   always_comb begin
      av_read  = slot.read && (wait_cnt >= SETUP);
      av_write = slot.write && (wait_cnt >= SETUP) && (wait_cnt <= WRITE_END);
      if (slot.write) begin
         slot.waitrequest = (wait_cnt != WRITE_DONE) | rst_override;
      end else begin
         slot.waitrequest = (wait_cnt != READ_DONE) | rst_override;
      end
   end

   // address is valid from cycle 0, so select covers setup too
   assign av_chipselect = cmd;

   // --------------------------------------------------
   // begintransfer, first cycle of each command only
   // --------------------------------------------------
   assign av_begintransfer = cmd & ~end_bt;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_bt <= 1'b0;
      end else if (!slot.waitrequest) begin
         end_bt <= 1'b0;   // next command starts fresh
      end else if (av_begintransfer && !rst_override) begin
         end_bt <= 1'b1;
      end
   end

   // --------------------------------------------------
   // read latency pipe
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lat_sr <= '0;
      end else begin
         lat_sr[0] <= rd_accept;
         for (int i = 1; i < LAT; i++) begin
            lat_sr[i] <= lat_sr[i-1];
         end
      end
   end

   assign slot.rvalid = lat_sr[LAT-1];   // lines up with slave readdata

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   a_no_rd_wr : assert property (@(posedge clk) disable iff (reset)
      !(slot.read && slot.write))
      else $error("wait_state_xlate: read and write together");

   a_cmd_held : assert property (@(posedge clk) disable iff (reset)
      (cmd && slot.waitrequest) |=> $stable({slot.read, slot.write}))
      else $error("wait_state_xlate: command changed under waitrequest");

endmodule

`default_nettype wire

// ==== src/read_return_mux.sv ====
/*
 * read return mux
 * merges the per-slot read returns into one readdata/readdatavalid
 */

`timescale 1ns/1ps
`default_nettype none

`include "avmm_xlate_config.svh"

module read_return_mux (
   xlate_slot_if.ret             slots [`AVX_NUM_SLOTS],
   output avmm_xlate_pkg::data_t uav_readdata,
   output logic                  uav_readdatavalid
);

   logic [`AVX_NUM_SLOTS-1:0] slot_valid;
   avmm_xlate_pkg::data_t     slot_data [`AVX_NUM_SLOTS];

   // --------------------------------------------------
   // gather slot returns
   // --------------------------------------------------
   generate
      for (genvar g = 0; g < `AVX_NUM_SLOTS; g++) begin : g_ret
         assign slot_valid[g] = slots[g].rvalid;
         assign slot_data[g]  = slots[g].rdata;
      end
   endgenerate

   assign uav_readdatavalid = |slot_valid;

   // and-or select, zero when nothing returns
   always_comb begin
      uav_readdata = '0;
      for (int i = 0; i < `AVX_NUM_SLOTS; i++) begin
         if (slot_valid[i]) begin
            uav_readdata = uav_readdata | slot_data[i];
         end
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // reads leave the slots in acceptance order, one per cycle at most
   a_one_return : assert final ($onehot0(slot_valid))
      else $error("read_return_mux: overlapping slot returns (%b)", slot_valid);

endmodule

`default_nettype wire

// ==== src/avmm_xlate_top.sv ====
/*
 * avalon-mm fabric endpoint
 * one universal avalon port fanned out to fixed-timing slave slots,
 * each with its own wait-state translator
 */

`timescale 1ns/1ps
`default_nettype none

`include "avmm_xlate_config.svh"

module avmm_xlate_top (
   input  logic                       clk,
   input  logic                       reset,

   // --------------------------------------------------
   // universal avalon port
   // --------------------------------------------------
   input  avmm_xlate_pkg::uav_addr_t  uav_address,
   input  logic                       uav_read,
   input  logic                       uav_write,
   input  avmm_xlate_pkg::data_t      uav_writedata,
   input  avmm_xlate_pkg::be_t        uav_byteenable,
   output logic                       uav_waitrequest,
   output avmm_xlate_pkg::data_t      uav_readdata,
   output logic                       uav_readdatavalid,

   // --------------------------------------------------
   // slave slots
   // --------------------------------------------------
   output avmm_xlate_pkg::word_addr_t av_address         [`AVX_NUM_SLOTS],
   output avmm_xlate_pkg::data_t      av_writedata       [`AVX_NUM_SLOTS],
   output avmm_xlate_pkg::be_t        av_byteenable      [`AVX_NUM_SLOTS],
   output avmm_xlate_pkg::be_t        av_writebyteenable [`AVX_NUM_SLOTS],
   output logic [`AVX_NUM_SLOTS-1:0]  av_read,
   output logic [`AVX_NUM_SLOTS-1:0]  av_write,
   output logic [`AVX_NUM_SLOTS-1:0]  av_chipselect,
   output logic [`AVX_NUM_SLOTS-1:0]  av_begintransfer,
   input  avmm_xlate_pkg::data_t      av_readdata        [`AVX_NUM_SLOTS]
);

   xlate_slot_if slot_if [`AVX_NUM_SLOTS] ();

   // address split and command steering
   slot_decoder u_slot_decoder (
      .uav_address     (uav_address),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .uav_writedata   (uav_writedata),
      .uav_byteenable  (uav_byteenable),
      .uav_waitrequest (uav_waitrequest),
      .slots           (slot_if)
   );

   // --------------------------------------------------
   // one translator per slot
   // --------------------------------------------------
   generate
      for (genvar g = 0; g < `AVX_NUM_SLOTS; g++) begin : g_slot
         wait_state_xlate u_wait_state_xlate (
            .clk                (clk),
            .reset              (reset),
            .slot               (slot_if[g]),
            .av_address         (av_address[g]),
            .av_writedata       (av_writedata[g]),
            .av_byteenable      (av_byteenable[g]),
            .av_writebyteenable (av_writebyteenable[g]),
            .av_read            (av_read[g]),
            .av_write           (av_write[g]),
            .av_chipselect      (av_chipselect[g]),
            .av_begintransfer   (av_begintransfer[g])
         );

         assign slot_if[g].rdata = av_readdata[g];   // slave data into the mux
      end
   endgenerate

   // merge read returns
   read_return_mux u_read_return_mux (
      .slots             (slot_if),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid)
   );

endmodule

`default_nettype wire

// ==== tb/avmm_xlate_checks.svh ====
/*
 * testbench helpers for the avalon fabric endpoint
 * random source, reference values, typed compares and directed tests
 */

`ifndef AVMM_XLATE_CHECKS_SVH
`define AVMM_XLATE_CHECKS_SVH

// --------------------------------------------------
// random source and reference model
// --------------------------------------------------
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// power-up contents, unique for every slot and word
function automatic avmm_xlate_pkg::data_t fill_word(input avmm_xlate_pkg::slot_id_t s,
                                                    input avmm_xlate_pkg::word_addr_t w);
   return {4'ha, s, 2'b01, w, w ^ 12'h5a5};
endfunction

function automatic avmm_xlate_pkg::data_t expected_word(input avmm_xlate_pkg::uav_addr_t a);
   int key;
   key = {a.f.slot, a.f.word};
   return shadow.exists(key) ? shadow[key] : fill_word(a.f.slot, a.f.word);
endfunction

function automatic void note_write(input avmm_xlate_pkg::uav_addr_t a,
                                   input avmm_xlate_pkg::data_t d, input avmm_xlate_pkg::be_t be);
   avmm_xlate_pkg::data_t word;
   word = expected_word(a);
   for (int b = 0; b < `AVX_BE_W; b++) begin
      if (be[b]) word[8*b +: 8] = d[8*b +: 8];   // byte lanes merge
   end
   shadow[{a.f.slot, a.f.word}] = word;
endfunction

// --------------------------------------------------
// compares
// --------------------------------------------------
task automatic check_data(input string what, input avmm_xlate_pkg::data_t exp, act);
   if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, got %h", cur_test, what, exp, act);
      err_count++;
   end
endtask

task automatic check_be(input string what, input avmm_xlate_pkg::be_t exp, act);
   if (exp !== act) begin
      $display("[ERROR] %s %s: expected %b, got %b", cur_test, what, exp, act);
      err_count++;
   end
endtask

task automatic check_addr(input string what, input avmm_xlate_pkg::word_addr_t exp, act);
   if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, got %h", cur_test, what, exp, act);
      err_count++;
   end
endtask

task automatic check_bit(input string what, input logic exp, act);
   if (exp !== act) begin
      $display("[ERROR] %s %s: expected %b, got %b", cur_test, what, exp, act);
      err_count++;
   end
endtask

task automatic end_test(input int errs_before);
   if (err_count == errs_before) begin
      $display("test %-10s ok", cur_test);
   end else begin
      $display("test %-10s FAILED, %0d mismatches", cur_test, err_count - errs_before);
      tests_failed++;
   end
endtask

// --------------------------------------------------
// bus driving, called on a rising edge
// --------------------------------------------------
// presents one command and follows it cycle by cycle until accepted
task automatic issue_cmd(input logic wr, input avmm_xlate_pkg::uav_addr_t addr,
                         input avmm_xlate_pkg::data_t data, input avmm_xlate_pkg::be_t be);
   int   s;
   int   cyc;
   int   done_cyc;
   logic accepted;
   s        = addr.f.slot;
   cyc      = 0;
   done_cyc = wr ? SETUP + WR_WAIT + HOLD : SETUP + RD_WAIT;
   accepted = 1'b0;
   uav_address    <= addr;
   uav_read       <= ~wr;
   uav_write      <= wr;
   uav_writedata  <= data;
   uav_byteenable <= be;
   while (!accepted && cyc < CMD_LIMIT) begin
      @(negedge clk);
      check_bit("waitrequest", cyc != done_cyc, uav_waitrequest);
      check_bit("begintransfer", cyc == 0, av_begintransfer[s]);
      check_bit("chipselect", 1'b1, av_chipselect[s]);
      check_addr("address", addr.f.word, av_address[s]);
      check_be("byteenable", be, av_byteenable[s]);
      if (wr) begin
         check_bit("write strobe", cyc >= SETUP && cyc <= SETUP + WR_WAIT, av_write[s]);
         check_be("writebyteenable", be, av_writebyteenable[s]);
         check_data("writedata", data, av_writedata[s]);
      end else begin
         check_bit("read strobe", cyc >= SETUP, av_read[s]);
         check_be("writebyteenable", '0, av_writebyteenable[s]);
      end
      for (int o = 0; o < N; o++) begin
         if (o != s) check_bit("idle slot", 1'b0, av_chipselect[o] | av_read[o] | av_write[o]);
      end
      if (!uav_waitrequest) begin
         accepted = 1'b1;
         if (!wr) begin
            exp_q.push_back(expected_word(addr));
            acc_q.push_back(cycle_no);
         end
      end
      cyc++;
      @(posedge clk);
   end
   if (!accepted) begin
      $display("%s: command to slot %0d was never accepted", cur_test, s);
      err_count++;
   end else if (wr) begin
      note_write(addr, data, be);
   end
endtask

task automatic drop_cmd();
   uav_read  <= 1'b0;
   uav_write <= 1'b0;
endtask

task automatic wait_returns();
   int n;
   n = 0;
   while (exp_q.size() != 0 && n < CMD_LIMIT) begin
      @(posedge clk);
      n++;
   end
   if (exp_q.size() != 0) begin
      $display("%s: %0d reads never returned data", cur_test, exp_q.size());
      err_count++;
      exp_q.delete();
      acc_q.delete();
   end
endtask

function automatic avmm_xlate_pkg::uav_addr_t rand_addr(input int slot);
   avmm_xlate_pkg::uav_addr_t a;
   logic [31:0]               r;
   r        = lcg_next();
   a.flat   = r[avmm_xlate_pkg::UAV_ADDR_W-1:0];   // lane is ignored by the endpoint
   a.f.slot = avmm_xlate_pkg::slot_id_t'(slot);
   return a;
endfunction

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic test_reset();
   int errs;
   errs     = err_count;
   cur_test = "reset";
   @(negedge clk);
   check_bit("waitrequest", 1'b1, uav_waitrequest);
   check_bit("av_read", 1'b0, |av_read);
   check_bit("av_write", 1'b0, |av_write);
   check_bit("av_chipselect", 1'b0, |av_chipselect);
   check_bit("av_begintransfer", 1'b0, |av_begintransfer);
   check_bit("readdatavalid", 1'b0, uav_readdatavalid);
   @(posedge clk);
   end_test(errs);
endtask

task automatic test_write();
   int errs;
   errs     = err_count;
   cur_test = "write";
   issue_cmd(1'b1, rand_addr(2), lcg_next(), avmm_xlate_pkg::be_t'(lcg_next() >> 8));
   issue_cmd(1'b1, rand_addr(0), lcg_next(), 4'hf);
   drop_cmd();
   @(posedge clk);
   end_test(errs);
endtask

task automatic test_read();
   avmm_xlate_pkg::uav_addr_t a;
   int                        errs;
   errs     = err_count;
   cur_test = "read";
   a        = rand_addr(3);
   issue_cmd(1'b1, a, lcg_next(), 4'hf);
   drop_cmd();
   @(posedge clk);
   issue_cmd(1'b0, a, '0, 4'hf);
   drop_cmd();
   wait_returns();
   end_test(errs);
endtask

task automatic test_pipelined();
   avmm_xlate_pkg::uav_addr_t addrs [8];
   int                        errs;
   errs     = err_count;
   cur_test = "pipelined";
   for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_addr(i % N);
      issue_cmd(1'b1, addrs[i], lcg_next(), 4'hf);
   end
   // reads go out back to back, no idle cycle between them
   for (int i = 0; i < 8; i++) begin
      issue_cmd(1'b0, addrs[i], '0, 4'hf);
   end
   drop_cmd();
   wait_returns();
   end_test(errs);
endtask

task automatic test_isolation();
   avmm_xlate_pkg::uav_addr_t a;
   int                        errs;
   errs     = err_count;
   cur_test = "isolation";
   for (int s = 0; s < N; s++) begin
      a = rand_addr(s);
      issue_cmd(1'b1, a, lcg_next(), 4'hf);
      issue_cmd(1'b0, a, '0, 4'hf);
      drop_cmd();
      @(negedge clk);
      check_bit("chipselect after command", 1'b0, |av_chipselect);
      @(posedge clk);
   end
   wait_returns();
   end_test(errs);
endtask

`endif

// ==== tb/avmm_xlate_tb.sv ====
/*
 * testbench for the avalon fabric endpoint
 * clock, reset, fixed-timing slave models, read return monitor, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "avmm_xlate_config.svh"

module avmm_xlate_tb;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 5;
   localparam int SETUP      = `AVX_SETUP_CYCLES;
   localparam int RD_WAIT    = `AVX_READ_WAIT_CYCLES;
   localparam int WR_WAIT    = `AVX_WRITE_WAIT_CYCLES;
   localparam int HOLD       = `AVX_HOLD_CYCLES;
   localparam int LAT        = `AVX_READ_LATENCY;
   localparam int N          = `AVX_NUM_SLOTS;
   localparam int CMD_LIMIT  = 16;   // cycles a command or return may take

   logic                       clk = 1'b0;
   logic                       reset;
   avmm_xlate_pkg::uav_addr_t  uav_address;
   logic                       uav_read;
   logic                       uav_write;
   avmm_xlate_pkg::data_t      uav_writedata;
   avmm_xlate_pkg::be_t        uav_byteenable;
   logic                       uav_waitrequest;
   avmm_xlate_pkg::data_t      uav_readdata;
   logic                       uav_readdatavalid;
   avmm_xlate_pkg::word_addr_t av_address [N];
   avmm_xlate_pkg::data_t      av_writedata [N];
   avmm_xlate_pkg::be_t        av_byteenable [N];
   avmm_xlate_pkg::be_t        av_writebyteenable [N];
   logic [N-1:0]               av_read;
   logic [N-1:0]               av_write;
   logic [N-1:0]               av_chipselect;
   logic [N-1:0]               av_begintransfer;
   avmm_xlate_pkg::data_t      av_readdata [N];

   avmm_xlate_pkg::data_t slave_mem [N][1 << `AVX_WORD_ADDR_W];
   avmm_xlate_pkg::data_t rd_pipe [N][LAT];   // slave read latency
   avmm_xlate_pkg::data_t shadow [int];       // expected contents, keyed by slot and word
   avmm_xlate_pkg::data_t exp_q [$];
   int                    acc_q [$];          // acceptance cycle of each read
   logic [31:0]           lcg_state;
   int                    cycle_no;
   int                    err_count;
   int                    tests_failed;
   string                 cur_test;

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cycle_no <= cycle_no + 1;

   avmm_xlate_top u_avmm_xlate_top (.*);

   `include "avmm_xlate_checks.svh"

   // --------------------------------------------------
   // fixed-timing slave models
   // --------------------------------------------------
   always @(posedge clk) begin
      for (int s = 0; s < N; s++) begin
         if (av_write[s]) begin
            for (int b = 0; b < `AVX_BE_W; b++) begin
               if (av_writebyteenable[s][b]) begin
                  slave_mem[s][av_address[s]][8*b +: 8] <= av_writedata[s][8*b +: 8];
               end
            end
         end
         // a slave without waitrequest sees the read accepted here
         rd_pipe[s][0] <= (av_read[s] && !uav_waitrequest) ? slave_mem[s][av_address[s]] : '0;
         for (int k = 1; k < LAT; k++) begin
            rd_pipe[s][k] <= rd_pipe[s][k-1];
         end
      end
   end

   always_comb begin
      for (int s = 0; s < N; s++) begin
         av_readdata[s] = rd_pipe[s][LAT-1];
      end
   end

   // read returns must come in issue order, L cycles after acceptance
   always @(negedge clk) begin : b_return
      int acc;
      if (!reset && uav_readdatavalid) begin
         if (exp_q.size() == 0) begin
            $display("%s: readdatavalid with no read outstanding", cur_test);
            err_count++;
         end else begin
            acc = acc_q.pop_front();
            check_data("readdata", exp_q.pop_front(), uav_readdata);
            if (cycle_no != acc + LAT) begin
               $display("[ERROR] %s return cycle: expected %0d, got %0d",
                        cur_test, acc + LAT, cycle_no);
               err_count++;
            end
         end
      end
   end

   // --------------------------------------------------
   // test sequence and watchdog
   // --------------------------------------------------
   initial begin
      lcg_state      = 32'h0a48683e;
      cycle_no       = 0;
      err_count      = 0;
      tests_failed   = 0;
      cur_test       = "setup";
      reset          = 1'b1;
      uav_address    = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      for (int s = 0; s < N; s++) begin
         for (int w = 0; w < (1 << `AVX_WORD_ADDR_W); w++) begin
            slave_mem[s][w] = fill_word(s, w);
         end
         for (int k = 0; k < LAT; k++) begin
            rd_pipe[s][k] = '0;
         end
      end
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      test_reset();
      test_write();
      test_read();
      test_pipelined();
      test_isolation();
      $display("%0d tests, %0d failed, %0d mismatches", NUM_TESTS, tests_failed, err_count);
      if (err_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("timeout: run still busy after %0d cycles, in test %s",
               NUM_TESTS * 200, cur_test);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== avmm_xlate.f ====
+incdir+src
+incdir+tb
src/avmm_xlate_pkg.sv
src/avmm_xlate_if.sv
src/slot_decoder.sv
src/wait_state_xlate.sv
src/read_return_mux.sv
src/avmm_xlate_top.sv
tb/avmm_xlate_tb.sv

// ==== Bender.yml ====
package:
  name: avmm_xlate

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/avmm_xlate_pkg.sv
      - src/avmm_xlate_if.sv
      - src/slot_decoder.sv
      - src/wait_state_xlate.sv
      - src/read_return_mux.sv
      - src/avmm_xlate_top.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/avmm_xlate_tb.sv
